// File: complex_matrix.f
verilog/cmx_pkg.sv
verilog/complex_add.sv
verilog/complex_matrix_add.sv
verilog/result_fifo.sv
verilog/complex_matrix_top.sv
verification/complex_matrix_assertions.sv
verification/complex_matrix_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
verilator --binary --timing --assert \
  --top-module complex_matrix_tb \
  -f complex_matrix.f \
  -o complex_matrix_sim \
  && ./obj_dir/complex_matrix_sim | tee /dev/stderr | grep -q "TEST OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verification/complex_matrix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module complex_matrix_tb;

  // Small array keeps the run short
  localparam int SIZE     = 4;
  localparam int DEPTH    = 2;
  localparam int OP_N     = 4 * SIZE;
  localparam int RES_N    = 2 * SIZE;
  localparam int TIMEOUT  = 100;
  localparam int STREAM_N = 200;

  typedef cmx_pkg::part_t [OP_N-1:0]  op_vec_t;
  typedef cmx_pkg::part_t [RES_N-1:0] res_vec_t;
  typedef logic [$clog2(OP_N)-1:0]    op_idx_t;
  typedef logic [$clog2(RES_N)-1:0]   res_idx_t;

  // DUT ports
  logic     clk_i;
  logic     rst_n_i;
  op_vec_t  operands_i;
  logic     in_valid_i;
  logic     in_ready_o;
  logic     flush_i;
  logic     sub_i;
  res_vec_t result_o;
  logic     out_valid_o;
  logic     out_ready_i;
  logic     busy_o;

  // Expected results in input order
  res_vec_t exp_q[$];
  integer   seed;
  int       pass_count;
  int       err_count;
  // Consumer ready pattern for the random stream
  bit       ready_pat [256];

  complex_matrix_top #(
    .SIZE  (SIZE),
    .DEPTH (DEPTH)
  ) UUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operands_i  (operands_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .sub_i       (sub_i),
    .result_o    (result_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  // Element i is a1,b1,a2,b2 at words 4i..4i+3, result re,im at 2i,2i+1
  function automatic res_vec_t expected_result(input op_vec_t ops, input bit sub);
    res_vec_t       r;
    cmx_pkg::part_t a1;
    cmx_pkg::part_t b1;
    cmx_pkg::part_t a2;
    cmx_pkg::part_t b2;
    for (int i = 0; i < SIZE; i++) begin
      a1 = ops[op_idx_t'(4*i)];
      b1 = ops[op_idx_t'(4*i+1)];
      a2 = ops[op_idx_t'(4*i+2)];
      b2 = ops[op_idx_t'(4*i+3)];
      // 64-bit arithmetic, wraps like the hardware
      r[res_idx_t'(2*i)]   = sub ? a1 - a2 : a1 + a2;
      r[res_idx_t'(2*i+1)] = sub ? b1 - b2 : b1 + b2;
    end
    return r;
  endfunction

  function automatic op_vec_t random_vector();
    op_vec_t v;
    for (int k = 0; k < OP_N; k++) begin
      v[op_idx_t'(k)] = {$random(seed), $random(seed)};
    end
    return v;
  endfunction

  // Corner values of a signed 64-bit part
  function automatic cmx_pkg::part_t edge_value(input int n);
    case (n % 5)
      0:       return 64'h7fff_ffff_ffff_ffff;
      1:       return 64'h8000_0000_0000_0000;
      2:       return 64'hffff_ffff_ffff_ffff;
      3:       return 64'h0000_0000_0000_0001;
      default: return 64'h0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("Error: %s got %h expected %h", name, got, expected);
      err_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_vector(input res_vec_t got_vec, input res_vec_t exp_vec);
    for (int k = 0; k < RES_N; k++) begin
      check_value($sformatf("result_o[%0d]", k), got_vec[res_idx_t'(k)],
                  exp_vec[res_idx_t'(k)]);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: no handshake on %s within %0d cycles", what, TIMEOUT);
    err_count++;
  endtask

  task automatic finish_test(input string name, input int start);
    $display("%s: done, %0d errors", name, err_count - start);
  endtask

  // Head of the output against the oldest expected entry
  task automatic compare_head();
    res_vec_t exp_vec;
    if (exp_q.size() == 0) begin
      $display("A result came out with no input left to match it");
      err_count++;
    end else begin
      exp_vec = exp_q.pop_front();
      check_vector(result_o, exp_vec);
    end
  endtask

  // Offer one vector and hold it until accepted
  task automatic send_vector(input op_vec_t ops, input bit sub);
    int cycles;
    bit accepted;
    cycles = 0;
    @(posedge clk_i);
    operands_i <= ops;
    sub_i      <= sub;
    in_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!in_ready_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    accepted = in_ready_o;
    // Transfer edge
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    if (accepted) begin
      exp_q.push_back(expected_result(ops, sub));
    end else begin
      report_timeout("in_ready_o");
    end
  endtask

  // Wait for a result with out_ready_i already high, count idle cycles
  task automatic receive_vector(output int waited);
    waited = 0;
    @(negedge clk_i);
    while (!(out_valid_o && out_ready_i) && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (out_valid_o && out_ready_i) begin
      compare_head();
    end else begin
      report_timeout("out_valid_o");
    end
    @(posedge clk_i);
  endtask

  task automatic test_reset();
    int start;
    start = err_count;
    @(negedge clk_i);
    check_value("in_ready_o", 64'(in_ready_o), 64'd1);
    check_value("out_valid_o", 64'(out_valid_o), 64'd0);
    check_value("busy_o", 64'(busy_o), 64'd0);
    finish_test("reset state", start);
  endtask

  task automatic test_add();
    op_vec_t ops;
    int      waited;
    int      start;
    start = err_count;
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    // Counting pattern makes word placement visible
    for (int k = 0; k < OP_N; k++) begin
      ops[op_idx_t'(k)] = cmx_pkg::part_t'(k + 1);
    end
    send_vector(ops, 1'b0);
    // Lane register holds it, buffer not yet
    @(negedge clk_i);
    check_value("out_valid_o", 64'(out_valid_o), 64'd0);
    receive_vector(waited);
    check_value("first result wait cycles", 64'(waited), 64'd0);
    for (int n = 0; n < 3; n++) begin
      send_vector(random_vector(), 1'b0);
      receive_vector(waited);
    end
    finish_test("addition", start);
  endtask

  task automatic test_sub_wrap();
    op_vec_t ops;
    int      waited;
    int      start;
    start = err_count;
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    // Rotate corner values through every operand slot
    for (int o = 0; o < 5; o++) begin
      for (int i = 0; i < SIZE; i++) begin
        for (int j = 0; j < 4; j++) begin
          ops[op_idx_t'(4*i+j)] = edge_value(i + j + o);
        end
      end
      send_vector(ops, 1'b1);
      receive_vector(waited);
    end
    finish_test("subtraction and wrap-around", start);
  endtask

  task automatic test_backpressure();
    int waited;
    int start;
    start = err_count;
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    // Two in the buffer, one in the lane register
    repeat (3) send_vector(random_vector(), 1'b0);
    @(negedge clk_i);
    // Stalled head is the oldest input
    for (int k = 0; k < 6; k++) begin
      check_value("in_ready_o", 64'(in_ready_o), 64'd0);
      check_value("out_valid_o", 64'(out_valid_o), 64'd1);
      check_vector(result_o, exp_q[0]);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    repeat (3) receive_vector(waited);
    // Nothing beyond the three results
    @(negedge clk_i);
    check_value("out_valid_o", 64'(out_valid_o), 64'd0);
    finish_test("back-pressure", start);
  endtask

  task automatic test_flush();
    int waited;
    int start;
    start = err_count;
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    // One result in the buffer, one in the lane register
    repeat (2) send_vector(random_vector(), 1'b1);
    flush_i    <= 1'b1;
    // Input offered with the flush is dropped too
    operands_i <= random_vector();
    in_valid_i <= 1'b1;
    @(posedge clk_i);
    flush_i    <= 1'b0;
    in_valid_i <= 1'b0;
    // Held results are gone
    exp_q.delete();
    @(negedge clk_i);
    check_value("out_valid_o", 64'(out_valid_o), 64'd0);
    check_value("busy_o", 64'(busy_o), 64'd0);
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    for (int k = 0; k < 5; k++) begin
      @(negedge clk_i);
      check_value("out_valid_o", 64'(out_valid_o), 64'd0);
    end
    // Fresh vector must come out, nothing stale before it
    send_vector(random_vector(), 1'b0);
    receive_vector(waited);
    @(negedge clk_i);
    check_value("out_valid_o", 64'(out_valid_o), 64'd0);
    finish_test("flush", start);
  endtask

  // Producer side of the random stream
  task automatic drive_stream();
    int gap;
    bit sub;
    for (int n = 0; n < STREAM_N; n++) begin
      gap = $random(seed) & 3;
      sub = ($random(seed) % 2) != 0;
      repeat (gap) @(posedge clk_i);
      send_vector(random_vector(), sub);
    end
  endtask

  // Consumer side, ready follows the pattern
  task automatic collect_stream();
    int rx_count;
    int cyc;
    rx_count = 0;
    cyc = 0;
    while (rx_count < STREAM_N && cyc < STREAM_N * 20) begin
      @(posedge clk_i);
      out_ready_i <= ready_pat[cyc[7:0]];
      @(negedge clk_i);
      if (out_valid_o && out_ready_i) begin
        compare_head();
        rx_count++;
      end
      cyc++;
    end
    if (rx_count < STREAM_N) begin
      report_timeout("random stream results");
    end
  endtask

  task automatic test_random_stream();
    int start;
    start = err_count;
    for (int k = 0; k < 256; k++) begin
      ready_pat[8'(k)] = ($random(seed) % 2) != 0;
    end
    fork
      drive_stream();
      collect_stream();
    join
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    // Everything drained, no extra result left
    @(negedge clk_i);
    check_value("out_valid_o", 64'(out_valid_o), 64'd0);
    check_value("busy_o", 64'(busy_o), 64'd0);
    check_value("expected queue size", 64'(exp_q.size()), 64'd0);
    finish_test("random stream", start);
  endtask

  initial begin
    seed        = 30;
    pass_count  = 0;
    err_count   = 0;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    operands_i  = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    sub_i       = 1'b0;
    out_ready_i = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset();
    test_add();
    test_sub_wrap();
    test_backpressure();
    test_flush();
    test_random_stream();
    $display("Summary: %0d checks passed, %0d errors", pass_count, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/complex_matrix_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module complex_matrix_assertions #(
  parameter int SIZE = 16
) (
  input logic                                              clk_i,
  input logic                                              rst_n_i,
  input logic                                              flush_i,
  input logic                                              out_ready_i,
  input logic                                              out_valid_o,
  input logic                                              busy_o,
  input cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM*SIZE-1:0]  result_o
);

  // Nothing held once reset has been seen
  a_reset_empty: assert property (@(posedge clk_i)
    !rst_n_i |=> !out_valid_o && !busy_o)
    else $error("out_valid_o or busy_o high after reset");

  // Stalled output keeps its data
  a_result_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(result_o))
    else $error("result_o changed or dropped while stalled");

  // Nothing held means no result now and none on the next edge
  a_busy_covers_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy_o |-> !out_valid_o ##1 !out_valid_o)
    else $error("out_valid_o high without a held result");

  // Flush empties the buffer head
  a_flush_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_o)
    else $error("out_valid_o high the cycle after flush_i");

endmodule

bind complex_matrix_top complex_matrix_assertions #(
  .SIZE (SIZE)
) u_assertions (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .out_ready_i (out_ready_i),
  .out_valid_o (out_valid_o),
  .busy_o      (busy_o),
  .result_o    (result_o)
);

`default_nettype wire

// File: verilog/complex_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module complex_matrix_top #(
  // Elements per vector
  parameter int SIZE  = 16,
  // Result buffer entries
  parameter int DEPTH = 2
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  // Operand vector, {b2,a2,b1,a1} per element
  input  cmx_pkg::part_t [cmx_pkg::OPS_PER_ELEM*SIZE-1:0]         operands_i,
  // Input handshake
  input  logic                                                     in_valid_i,
  output logic                                                     in_ready_o,
  input  logic                                                     flush_i,
  input  logic                                                     sub_i,
  // Result vector, {im,re} per element
  output cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM*SIZE-1:0]         result_o,
  // Output handshake
  output logic                                                     out_valid_o,
  input  logic                                                     out_ready_i,
  // Any result held inside
  output logic                                                     busy_o
);

  // Lane array to buffer
  logic                                                array_valid;
  logic                                                array_ready;
  logic                                                array_busy;
  cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM*SIZE-1:0]    array_result;

  // Buffer holds at least one result
  logic                                                fifo_not_empty;

  // Lane array, one cycle of latency
  complex_matrix_add #(
    .SIZE (SIZE)
  ) u_complex_matrix_add (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operands_i  (operands_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .sub_i       (sub_i),
    .result_o    (array_result),
    .out_valid_o (array_valid),
    // Back-pressure from the buffer
    .out_ready_i (array_ready),
    .busy_o      (array_busy)
  );

  // Result buffer, decouples the lanes from the consumer
  result_fifo #(
    .SIZE  (SIZE),
    .DEPTH (DEPTH)
  ) u_result_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .push_valid_i (array_valid),
    .push_data_i  (array_result),
    .push_ready_o (array_ready),
    .pop_valid_o  (out_valid_o),
    .pop_ready_i  (out_ready_i),
    .pop_data_o   (result_o),
    .not_empty_o  (fifo_not_empty)
  );

  // Busy while a result sits in the lanes or in the buffer
  assign busy_o = array_busy | fifo_not_empty;

endmodule

`default_nettype wire

// File: verilog/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module result_fifo #(
  parameter int SIZE  = 16,
  // Entries, power of two
  parameter int DEPTH = 2
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic                                                     flush_i,
  // Write side
  input  logic                                                     push_valid_i,
  input  cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM*SIZE-1:0]         push_data_i,
  output logic                                                     push_ready_o,
  // Read side
  output logic                                                     pop_valid_o,
  input  logic                                                     pop_ready_i,
  output cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM*SIZE-1:0]         pop_data_o,
  // At least one entry stored
  output logic                                                     not_empty_o
);

  // Pointer and count widths
  // Count needs one more value than the pointer
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM*SIZE-1:0] entry_t;

  // Storage, one full result vector per entry
  entry_t mem_q [DEPTH];

  // Control state
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;

  // Status and transfer qualifiers
  logic full;
  logic empty;
  logic push;
  logic pop;

  // Circular increment
  // Explicit wrap so a count that is not a power of two stays in range
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  assign full  = (count_q == cnt_t'(DEPTH));
  assign empty = (count_q == '0);

  // Full buffer still takes a push when the head leaves this cycle
  assign push_ready_o = ~full | pop_ready_i;
  assign pop_valid_o  = ~empty;
  assign not_empty_o  = ~empty;

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_ready_i & ~empty;

  // Head of the buffer
  assign pop_data_o = mem_q[rd_ptr_q];

  // Pointers and count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Drop everything stored, incoming data included
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Count moves only when one side transfers alone
      case ({push, pop})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry write
  // A write during flush lands in a slot the reset pointers ignore
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/complex_matrix_add.sv
`timescale 1ns/1ps
`default_nettype none

module complex_matrix_add #(
  parameter int SIZE = 16
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  // Operand words, element i at 4i..4i+3
  input  cmx_pkg::part_t [cmx_pkg::OPS_PER_ELEM*SIZE-1:0]         operands_i,
  // Input handshake
  input  logic                                                     in_valid_i,
  output logic                                                     in_ready_o,
  input  logic                                                     flush_i,
  input  logic                                                     sub_i,
  // Result words, element i at 2i..2i+1
  output cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM*SIZE-1:0]         result_o,
  // Output handshake
  output logic                                                     out_valid_o,
  input  logic                                                     out_ready_i,
  // Data held in the lanes
  output logic                                                     busy_o
);

  // Per lane handshake bits
  logic [SIZE-1:0] lane_in_ready;
  logic [SIZE-1:0] lane_out_valid;
  logic [SIZE-1:0] lane_busy;

  // Lanes share every control input so they move together
  // AND reduction keeps the array view consistent anyway
  assign in_ready_o  = &lane_in_ready;
  assign out_valid_o = &lane_out_valid;
  assign busy_o      = &lane_busy;

  for (genvar i = 0; i < SIZE; i++) begin : add_loop
    complex_add u_complex_add (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      // Slice {b2,a2,b1,a1} of element i
      .operands_i  (operands_i[cmx_pkg::OPS_PER_ELEM*i +: cmx_pkg::OPS_PER_ELEM]),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (lane_in_ready[i]),
      .flush_i     (flush_i),
      .sub_i       (sub_i),
      // Slice {im,re} of element i
      .result_o    (result_o[cmx_pkg::RES_PER_ELEM*i +: cmx_pkg::RES_PER_ELEM]),
      .out_valid_o (lane_out_valid[i]),
      .out_ready_i (out_ready_i),
      .busy_o      (lane_busy[i])
    );
  end

endmodule

`default_nettype wire

// File: verilog/complex_add.sv
`timescale 1ns/1ps
`default_nettype none

module complex_add (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Operand slice of one element, {b2,a2,b1,a1}
  input  cmx_pkg::part_t [cmx_pkg::OPS_PER_ELEM-1:0]   operands_i,
  // Input handshake
  input  logic                                          in_valid_i,
  output logic                                          in_ready_o,
  input  logic                                          flush_i,
  input  logic                                          sub_i,
  // Result slice, {im,re}
  output cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM-1:0]   result_o,
  // Output handshake
  output logic                                          out_valid_o,
  input  logic                                          out_ready_i,
  // Result held in the output register
  output logic                                          busy_o
);

  // Output register state
  logic                                          valid_q;
  cmx_pkg::part_t [cmx_pkg::RES_PER_ELEM-1:0]   result_q;

  // Next result, computed straight from the inputs
  cmx_pkg::part_t                                re_d;
  cmx_pkg::part_t                                im_d;

  // Handshake qualifier
  logic                                          accept;

  // Register free, or emptied by the consumer this cycle
  assign in_ready_o = ~valid_q | out_ready_i;
  assign accept     = in_valid_i & in_ready_o;

  // Add or subtract, chosen per input
  // Plain two's complement arithmetic, carry out is dropped
  always_comb begin
    if (sub_i) begin
      re_d = operands_i[cmx_pkg::IDX_A1] - operands_i[cmx_pkg::IDX_A2];
      im_d = operands_i[cmx_pkg::IDX_B1] - operands_i[cmx_pkg::IDX_B2];
    end else begin
      re_d = operands_i[cmx_pkg::IDX_A1] + operands_i[cmx_pkg::IDX_A2];
      im_d = operands_i[cmx_pkg::IDX_B1] + operands_i[cmx_pkg::IDX_B2];
    end
  end

  // Valid bit
  // Flush wins over any input offered in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      // Either refilled or drained
      valid_q <= in_valid_i;
    end
  end

  // Result payload
  // Only loaded on a transfer, held while stalled
  always_ff @(posedge clk_i) begin
    if (accept) begin
      result_q[cmx_pkg::IDX_RE] <= re_d;
      result_q[cmx_pkg::IDX_IM] <= im_d;
    end
  end

  assign result_o    = result_q;
  assign out_valid_o = valid_q;

  // Only storage in the lane is the output register
  assign busy_o = valid_q;

endmodule

`default_nettype wire

// File: verilog/cmx_pkg.sv
`default_nettype none

package cmx_pkg;

  // Width of one real or imaginary part
  // 64-bit two's complement fixed point
  localparam int PART_W = 64;

  // Parts per element on the operand side
  // Order inside an element is a1, b1, a2, b2
  localparam int OPS_PER_ELEM = 4;

  // Parts per element on the result side
  // Real part first, then imaginary part
  localparam int RES_PER_ELEM = 2;

  // Word positions inside one element's operand slice
  localparam int IDX_A1 = 0;
  localparam int IDX_B1 = 1;
  localparam int IDX_A2 = 2;
  localparam int IDX_B2 = 3;

  // Word positions inside one element's result slice
  localparam int IDX_RE = 0;
  localparam int IDX_IM = 1;

  // One signed part, wraps on overflow
  typedef logic signed [PART_W-1:0] part_t;

endpackage

`default_nettype wire
